//--- hw/ppu_out_pkg.sv
// Shared pixel, colour and credit types plus range constants for the video output path and its testbench
`default_nettype none

package ppu_out_pkg;

  // ======================================================================
  // Pixel types
  // ======================================================================

  // One colour channel
  typedef logic [7:0] color_t;

  // Packed colour triple, red in the top byte and blue in the bottom byte
  typedef logic [23:0] rgb_t;

  // Sync flags as {VSYNC, DE, HSYNC}
  typedef logic [2:0] sync_t;

  // ======================================================================
  // Scanline and flow control types
  // ======================================================================

  // User scanline strength, 0 is the weakest setting
  typedef logic [3:0] sl_str_t;

  // Strength after expansion to the full 8-bit factor
  typedef logic [7:0] sl_factor_t;

  // Credit counter, covers buffer depths up to 15
  typedef logic [3:0] credit_t;

  // ======================================================================
  // Constants
  // ======================================================================

  // Scale factor of the limited-range conversion (235 - 16 + 1)
  localparam color_t LIMIT_COEFF = 8'd220;

  // Black level of limited-range RGB
  localparam color_t LIMIT_OFFSET = 8'd16;

  // Pixel buffer depth used unless the top level overrides it
  localparam int DEFAULT_DEPTH = 8;

endpackage

`default_nettype wire

//--- hw/scanline_shader.sv
// Producer stage: accepts input pixels against buffer credits and darkens scanline rows
`timescale 1ns/10ps
`default_nettype none

module scanline_shader #(
  parameter int FIFO_DEPTH = ppu_out_pkg::DEFAULT_DEPTH
) (
  input  wire                       VCLK_Tx,
  input  wire                       nVRST_Tx,
  input  wire                       pix_valid_i,
  output logic                      pix_ready_o,
  input  wire ppu_out_pkg::rgb_t    pix_rgb_i,
  input  wire ppu_out_pkg::sync_t   pix_sync_i,
  input  wire                       pix_sl_row_i,
  input  wire                       sl_en_i,
  input  wire ppu_out_pkg::sl_str_t sl_strength_i,
  input  wire                       credit_return_i,
  output logic                      push_o,
  output ppu_out_pkg::rgb_t         push_rgb_o,
  output ppu_out_pkg::sync_t        push_sync_o
);

  ppu_out_pkg::credit_t    credit_cnt;
  ppu_out_pkg::sl_factor_t sl_factor;
  logic [8:0]              sl_weight;
  logic                    accept;
  logic                    darken;
  ppu_out_pkg::rgb_t       shaded_rgb;

  // Scales one channel by weight/256, result always fits 8 bits
  function automatic ppu_out_pkg::color_t shade_chan(input ppu_out_pkg::color_t c,
                                                     input logic [8:0] w);
    logic [16:0] prod;
    prod = {9'd0, c} * {8'd0, w};
    return prod[15:8];
  endfunction

  // ======================================================================
  // Credit handling
  // ======================================================================

  assign pix_ready_o = (credit_cnt != '0);
  assign accept      = pix_valid_i & pix_ready_o;

  // Accept and credit return may coincide and then cancel out
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      credit_cnt <= ppu_out_pkg::credit_t'(FIFO_DEPTH);
    end else begin
      case ({accept, credit_return_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // ======================================================================
  // Scanline darkening
  // ======================================================================

  // f = (s+1)*16 - 1, i.e. strength in the upper nibble and ones below
  assign sl_factor = {sl_strength_i, 4'hF};
  assign sl_weight = 9'd256 - {1'b0, sl_factor};
  assign darken    = sl_en_i & pix_sl_row_i;

  always_comb begin
    shaded_rgb[23:16] = shade_chan(pix_rgb_i[23:16], sl_weight);
    shaded_rgb[15:8]  = shade_chan(pix_rgb_i[15:8], sl_weight);
    shaded_rgb[7:0]   = shade_chan(pix_rgb_i[7:0], sl_weight);
  end

  // Push strobe, one cycle after acceptance
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      push_o <= 1'b0;
    end else begin
      push_o <= accept;
    end
  end

  // Pixel payload, sync flags pass untouched
  always_ff @(posedge VCLK_Tx) begin
    if (accept) begin
      push_rgb_o  <= darken ? shaded_rgb : pix_rgb_i;
      push_sync_o <= pix_sync_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/pixel_credit_fifo.sv
// Circular pixel buffer between shader and output stage, returns one credit per entry popped
`timescale 1ns/10ps
`default_nettype none

module pixel_credit_fifo #(
  parameter int FIFO_DEPTH = ppu_out_pkg::DEFAULT_DEPTH
) (
  input  wire                     VCLK_Tx,
  input  wire                     nVRST_Tx,
  input  wire                     push_i,
  input  wire ppu_out_pkg::rgb_t  push_rgb_i,
  input  wire ppu_out_pkg::sync_t push_sync_i,
  input  wire                     pop_i,
  output logic                    not_empty_o,
  output ppu_out_pkg::rgb_t       head_rgb_o,
  output ppu_out_pkg::sync_t      head_sync_o,
  output logic                    credit_return_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  ppu_out_pkg::rgb_t    mem_rgb  [FIFO_DEPTH];
  ppu_out_pkg::sync_t   mem_sync [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  ppu_out_pkg::credit_t fill_cnt;
  logic                 do_pop;

  // Pointer increment with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign not_empty_o = (fill_cnt != '0);
  assign do_pop      = pop_i & not_empty_o;
  assign head_rgb_o  = mem_rgb[rd_ptr];
  assign head_sync_o = mem_sync[rd_ptr];

  // ======================================================================
  // Storage
  // ======================================================================

  // No full check here, the producer never pushes without a credit
  always_ff @(posedge VCLK_Tx) begin
    if (push_i) begin
      mem_rgb[wr_ptr]  <= push_rgb_i;
      mem_sync[wr_ptr] <= push_sync_i;
    end
  end

  // ======================================================================
  // Pointers, fill level and credit return
  // ======================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      fill_cnt        <= '0;
      credit_return_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push_i, do_pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
      // Credit goes back the cycle after the pop
      credit_return_o <= do_pop;
    end
  end

endmodule

`default_nettype wire

//--- hw/rgb_range_out.sv
// Output stage: pops the pixel buffer, applies optional limited-range RGB and registers video outputs
`timescale 1ns/10ps
`default_nettype none

module rgb_range_out (
  input  wire                     VCLK_Tx,
  input  wire                     nVRST_Tx,
  input  wire                     not_empty_i,
  input  wire ppu_out_pkg::rgb_t  head_rgb_i,
  input  wire ppu_out_pkg::sync_t head_sync_i,
  input  wire                     limited_rgb_i,
  input  wire                     sink_ready_i,
  output logic                    pop_o,
  output logic                    out_valid_o,
  output ppu_out_pkg::rgb_t       VD_o,
  output logic                    DE_o,
  output logic                    HSYNC_o,
  output logic                    VSYNC_o
);

  logic                          advance;
  logic                          s1_valid;
  logic                          s2_valid;
  logic [2:0][8:0]               s1_lim;
  ppu_out_pkg::color_t [2:0]     s2_lim;
  ppu_out_pkg::rgb_t             s1_rgb;
  ppu_out_pkg::rgb_t             s2_rgb;
  ppu_out_pkg::sync_t            s1_sync;
  ppu_out_pkg::sync_t            s2_sync;

  // c*220, keeping product bits 15..7
  function automatic logic [8:0] limit_scale(input ppu_out_pkg::color_t c);
    logic [15:0] prod;
    prod = 16'(c) * 16'(ppu_out_pkg::LIMIT_COEFF);
    return prod[15:7];
  endfunction

  // Pipeline moves unless the output register is full and stalled
  assign advance = ~out_valid_o | sink_ready_i;
  assign pop_o   = not_empty_i & advance;

  // ======================================================================
  // Valid chain
  // ======================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      out_valid_o <= 1'b0;
    end else if (advance) begin
      s1_valid    <= pop_o;
      s2_valid    <= s1_valid;
      out_valid_o <= s2_valid;
    end
  end

  // ======================================================================
  // Stage 1 scale and stage 2 round
  // ======================================================================

  always_ff @(posedge VCLK_Tx) begin
    if (pop_o) begin
      for (int i = 0; i < 3; i++) begin
        s1_lim[i] <= limit_scale(head_rgb_i[8*i +: 8]);
      end
      s1_rgb  <= head_rgb_i;
      s1_sync <= head_sync_i;
    end
    // Round half up by adding the dropped LSB
    if (advance && s1_valid) begin
      for (int i = 0; i < 3; i++) begin
        s2_lim[i] <= s1_lim[i][8:1] + {7'd0, s1_lim[i][0]};
      end
      s2_rgb  <= s1_rgb;
      s2_sync <= s1_sync;
    end
  end

  // ======================================================================
  // Stage 3, black level offset and output registers
  // ======================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      VD_o    <= '0;
      VSYNC_o <= 1'b0;
      DE_o    <= 1'b0;
      HSYNC_o <= 1'b0;
    end else if (advance && s2_valid) begin
      if (limited_rgb_i) begin
        for (int i = 0; i < 3; i++) begin
          VD_o[8*i +: 8] <= s2_lim[i] + ppu_out_pkg::LIMIT_OFFSET;
        end
      end else begin
        VD_o <= s2_rgb;
      end
      VSYNC_o <= s2_sync[2];
      DE_o    <= s2_sync[1];
      HSYNC_o <= s2_sync[0];
    end
  end

endmodule

`default_nettype wire

//--- hw/ppu_out_top.sv
// Top level of the video output path: scanline shader, credit buffer and range output stage
`timescale 1ns/10ps
`default_nettype none

module ppu_out_top #(
  parameter int FIFO_DEPTH = ppu_out_pkg::DEFAULT_DEPTH
) (
  input  wire                       VCLK_Tx,
  input  wire                       nVRST_Tx,
  input  wire                       pix_valid_i,
  output logic                      pix_ready_o,
  input  wire ppu_out_pkg::rgb_t    pix_rgb_i,
  input  wire ppu_out_pkg::sync_t   pix_sync_i,
  input  wire                       pix_sl_row_i,
  input  wire                       sl_en_i,
  input  wire ppu_out_pkg::sl_str_t sl_strength_i,
  input  wire                       limited_rgb_i,
  input  wire                       sink_ready_i,
  output logic                      out_valid_o,
  output ppu_out_pkg::rgb_t         VD_o,
  output logic                      DE_o,
  output logic                      HSYNC_o,
  output logic                      VSYNC_o
);

  // Shader to buffer
  logic               push;
  ppu_out_pkg::rgb_t  push_rgb;
  ppu_out_pkg::sync_t push_sync;
  logic               credit_return;

  // Buffer to output stage
  logic               not_empty;
  ppu_out_pkg::rgb_t  head_rgb;
  ppu_out_pkg::sync_t head_sync;
  logic               pop;

  // ======================================================================
  // Stage instances
  // ======================================================================

  scanline_shader #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_scanline_shader (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .pix_valid_i    (pix_valid_i),
    .pix_ready_o    (pix_ready_o),
    .pix_rgb_i      (pix_rgb_i),
    .pix_sync_i     (pix_sync_i),
    .pix_sl_row_i   (pix_sl_row_i),
    .sl_en_i        (sl_en_i),
    .sl_strength_i  (sl_strength_i),
    .credit_return_i(credit_return),
    .push_o         (push),
    .push_rgb_o     (push_rgb),
    .push_sync_o    (push_sync)
  );

  pixel_credit_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_pixel_credit_fifo (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .push_i         (push),
    .push_rgb_i     (push_rgb),
    .push_sync_i    (push_sync),
    .pop_i          (pop),
    .not_empty_o    (not_empty),
    .head_rgb_o     (head_rgb),
    .head_sync_o    (head_sync),
    .credit_return_o(credit_return)
  );

  rgb_range_out u_rgb_range_out (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .not_empty_i  (not_empty),
    .head_rgb_i   (head_rgb),
    .head_sync_i  (head_sync),
    .limited_rgb_i(limited_rgb_i),
    .sink_ready_i (sink_ready_i),
    .pop_o        (pop),
    .out_valid_o  (out_valid_o),
    .VD_o         (VD_o),
    .DE_o         (DE_o),
    .HSYNC_o      (HSYNC_o),
    .VSYNC_o      (VSYNC_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_ppu_out.sv
// Self-checking testbench for the video output path, replays sim/pixel_cases.txt through the DUT
`timescale 1ns/10ps
`default_nettype none

module tb_ppu_out;

  // Odd depth so the buffer pointers wrap at a non power of two
  localparam int DEPTH      = 5;
  localparam int PIPE_SLOTS = 3;
  localparam int MAX_CASES  = 64;
  localparam int CLK_HALF   = 10;
  localparam int DRIVE_DLY  = 2;

  logic                 VCLK_Tx;
  logic                 nVRST_Tx;
  logic                 pix_valid_i;
  logic                 pix_ready_o;
  ppu_out_pkg::rgb_t    pix_rgb_i;
  ppu_out_pkg::sync_t   pix_sync_i;
  logic                 pix_sl_row_i;
  logic                 sl_en_i;
  ppu_out_pkg::sl_str_t sl_strength_i;
  logic                 limited_rgb_i;
  logic                 sink_ready_i;
  logic                 out_valid_o;
  ppu_out_pkg::rgb_t    VD_o;
  logic                 DE_o;
  logic                 HSYNC_o;
  logic                 VSYNC_o;

  // {sl_en, strength, limited, sl_row} nibbles, input rgb, sync nibble, expected rgb
  logic [67:0]          case_mem [MAX_CASES];
  int                   n_cases;
  ppu_out_pkg::rgb_t    exp_rgb_q[$];
  ppu_out_pkg::sync_t   exp_sync_q[$];
  ppu_out_pkg::rgb_t    drv_exp_rgb;
  int                   accepted;
  int                   transferred;
  integer               seed;
  logic                 hold_sink;
  logic                 stall_seen;
  logic                 seen_valid;

  ppu_out_top #(
    .FIFO_DEPTH(DEPTH)
  ) u_ppu_out_top (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .pix_valid_i  (pix_valid_i),
    .pix_ready_o  (pix_ready_o),
    .pix_rgb_i    (pix_rgb_i),
    .pix_sync_i   (pix_sync_i),
    .pix_sl_row_i (pix_sl_row_i),
    .sl_en_i      (sl_en_i),
    .sl_strength_i(sl_strength_i),
    .limited_rgb_i(limited_rgb_i),
    .sink_ready_i (sink_ready_i),
    .out_valid_o  (out_valid_o),
    .VD_o         (VD_o),
    .DE_o         (DE_o),
    .HSYNC_o      (HSYNC_o),
    .VSYNC_o      (VSYNC_o)
  );

  initial VCLK_Tx = 1'b0;
  always #CLK_HALF VCLK_Tx = ~VCLK_Tx;

  // ======================================================================
  // Compare and error tasks
  // ======================================================================

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_rgb(input string name, input ppu_out_pkg::rgb_t got,
                           input ppu_out_pkg::rgb_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_sync(input string name, input ppu_out_pkg::sync_t got,
                            input ppu_out_pkg::sync_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_credit(input string name, input ppu_out_pkg::credit_t got,
                              input ppu_out_pkg::credit_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  // ======================================================================
  // Stimulus helpers
  // ======================================================================

  task automatic apply_case(input int idx);
    logic [67:0] c;
    c             = case_mem[idx];
    sl_en_i       = c[64];
    sl_strength_i = c[63:60];
    limited_rgb_i = c[56];
    pix_sl_row_i  = c[52];
    pix_rgb_i     = c[51:28];
    pix_sync_i    = c[26:24];
    drv_exp_rgb   = c[23:0];
    pix_valid_i   = 1'b1;
  endtask

  // Buffer plus the three output stages are full when credits run out
  task automatic check_stall();
    check_credit("pixels_in_flight", ppu_out_pkg::credit_t'(accepted - transferred),
                 ppu_out_pkg::credit_t'(DEPTH + PIPE_SLOTS));
    stall_seen = 1'b1;
    hold_sink  = 1'b0;
  endtask

  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge VCLK_Tx);
      if (pix_ready_o) begin
        taken = 1'b1;
      end else if (hold_sink) begin
        check_stall();
      end
      @(posedge VCLK_Tx);
      #DRIVE_DLY;
    end
    pix_valid_i = 1'b0;
  endtask

  task automatic drain_outputs();
    while (exp_rgb_q.size() != 0) begin
      @(posedge VCLK_Tx);
      #DRIVE_DLY;
    end
  endtask

  // ======================================================================
  // Sink and scoreboard
  // ======================================================================

  always @(posedge VCLK_Tx) begin : sink_drive
    logic [31:0] r;
    #DRIVE_DLY;
    r            = $random(seed);
    sink_ready_i = hold_sink ? 1'b0 : r[0];
  end

  // Sampled mid-cycle, where inputs and registered outputs are settled
  always @(negedge VCLK_Tx) begin : monitor
    ppu_out_pkg::rgb_t  exp_rgb;
    ppu_out_pkg::sync_t exp_sync;
    if (nVRST_Tx) begin
      if (pix_valid_i && pix_ready_o) begin
        exp_rgb_q.push_back(drv_exp_rgb);
        exp_sync_q.push_back(pix_sync_i);
        accepted++;
      end
      if (!seen_valid) begin
        if (out_valid_o) begin
          seen_valid = 1'b1;
        end else begin
          check_rgb("VD_o", VD_o, '0);
          check_sync("sync_out", {VSYNC_o, DE_o, HSYNC_o}, '0);
        end
      end
      if (out_valid_o && sink_ready_i) begin
        if (exp_rgb_q.size() == 0) begin
          fail_run("An output pixel was transferred while no pixel was pending");
        end else begin
          exp_rgb  = exp_rgb_q.pop_front();
          exp_sync = exp_sync_q.pop_front();
          check_rgb("VD_o", VD_o, exp_rgb);
          check_sync("sync_out", {VSYNC_o, DE_o, HSYNC_o}, exp_sync);
          transferred++;
        end
      end
      if (accepted - transferred > DEPTH + PIPE_SLOTS) begin
        fail_run("More pixels were accepted than the buffer and pipeline can hold");
      end
    end
  end

  initial begin : watchdog
    int limit;
    #1;
    limit = n_cases * 40 + 200;
    repeat (limit) @(posedge VCLK_Tx);
    fail_run("Timeout: the outputs stalled before every pixel came out");
  end

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin : main_seq
    seed          = 38;
    nVRST_Tx      = 1'b0;
    pix_valid_i   = 1'b0;
    pix_rgb_i     = '0;
    pix_sync_i    = '0;
    pix_sl_row_i  = 1'b0;
    sl_en_i       = 1'b0;
    sl_strength_i = '0;
    limited_rgb_i = 1'b0;
    sink_ready_i  = 1'b0;
    drv_exp_rgb   = '0;
    accepted      = 0;
    transferred   = 0;
    hold_sink     = 1'b1;
    stall_seen    = 1'b0;
    seen_valid    = 1'b0;
    for (int i = 0; i < MAX_CASES; i++) begin
      case_mem[i] = '1;
    end
    $readmemh("sim/pixel_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_mem[n_cases][67:64] != 4'hF) begin
      n_cases++;
    end
    repeat (4) @(posedge VCLK_Tx);
    #DRIVE_DLY;
    nVRST_Tx = 1'b1;
    @(negedge VCLK_Tx);
    check_flag("pix_ready_o", pix_ready_o, 1'b1);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    @(posedge VCLK_Tx);
    #DRIVE_DLY;
    // Sink starts held off, first group fills buffer and pipeline
    for (int i = 0; i < n_cases; i++) begin
      if (i > 0 && case_mem[i][67:56] != case_mem[i-1][67:56]) begin
        drain_outputs();
      end
      apply_case(i);
      wait_accept();
    end
    drain_outputs();
    repeat (10) @(posedge VCLK_Tx);
    if (!stall_seen) begin
      fail_run("pix_ready_o never fell while the sink was held off");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim/pixel_cases.txt
// Digits: sl_en, strength, limited, sl_row, input rgb (6), sync {VSYNC,DE,HSYNC} (1), expected rgb (6)
// Pass-through, first group also fills the buffer while the sink is held off
00000000000000000
0000FFFFFF2FFFFFF
00001234563123456
0001ABCDEF2ABCDEF
000080407F680407F
00000102034010203
0001FEDCBA1FEDCBA
00005A5AA575A5AA5
00000F0F0F20F0F0F
// Scanline darkening at strengths 0, 15, 7, 3 and 11
1001FFFFFF2F0F0F0
10018040202783C1E
10008040202804020
1F01FFFFFF2000000
1F00FFFFFF3FFFFFF
1701FF80012804000
17001020302102030
1701C864326643219
1301FFFFFF2C0C0C0
13010A1E64207164B
1B01FF7F012402000
1B00FF7F012FF7F01
// Limited range only
00100000002101010
0010FFFFFF2EBEBEB
001080402037E472C
001001FF00211EB10
0010C864322BC663B
00110A7F106197D1E
00100203F001213DE
// Scanline darkening followed by limited range
1011FFFFFF2DEDEDE
1010FFFFFF2EBEBEB
1311FFFFFF2B5B5B5
1F11FFFFFF2101010
1711F07840277442C
1710F078402DE7747
// Pass-through again under a random sink
00001122332112233
00004455662445566
00007788992778899
0000AABBCC2AABBCC
0000DDEEFF3DDEEFF
00000F1E2D20F1E2D

//--- project.f
hw/ppu_out_pkg.sv
hw/scanline_shader.sv
hw/pixel_credit_fifo.sv
hw/rgb_range_out.sv
hw/ppu_out_top.sv
sim/tb_ppu_out.sv

//--- Makefile
# Verilator build and run of the video output path testbench

TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_ppu_out
FILELIST := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
